//--- Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_access.sv
  - csr_machine_regs.sv
  - csr_counters.sv
  - csr_unit.sv
  - target: simulation
    files:
      - tb_csr_unit.sv

//--- csr_access.sv
// CSR access decode and read mux
`timescale 1ns/1ps
`default_nettype none

module csr_access
    import csr_pkg::*;
#(
    parameter logic [31:0] HART_ID = 32'd0
) (
    input  csr_req_t    req_i,
    input  logic [31:0] mach_rdata_i,
    input  logic [63:0] mcycle_i,
    input  logic [63:0] minstret_i,
    input  logic [63:0] mtime_i,
    output csr_addr_e   mach_addr_o,
    output csr_wr_t     wr_o,
    output logic [31:0] rdata_o
);

    localparam logic [31:0] MASK_MSTATUS = 32'h007E_19AA;
    localparam logic [31:0] MASK_MISA    = 32'h3C00_0000;
    localparam logic [31:0] MASK_MIE     = 32'h0000_0888;
    localparam logic [31:0] MASK_ALIGN   = 32'hFFFF_FFFC;  // mtvec and mepc

    csr_addr_e   addr;
    logic [31:0] cur_val;
    logic [31:0] wmask;
    logic [31:0] op_val;
    csr_wr_sel_t sel;

    assign addr        = csr_addr_e'(req_i.addr);
    assign mach_addr_o = addr;

    // Current value, write mask and target per address
    always_comb begin
        cur_val = '0;
        wmask   = '0;
        sel     = '0;
        case (addr)
            CSR_MSTATUS: begin
                cur_val  = mach_rdata_i;
                wmask    = MASK_MSTATUS;
                sel.mach = 1'b1;
            end
            CSR_MISA: begin
                cur_val  = mach_rdata_i;
                wmask    = MASK_MISA;
                sel.mach = 1'b1;
            end
            CSR_MIE: begin
                cur_val  = mach_rdata_i;
                wmask    = MASK_MIE;
                sel.mach = 1'b1;
            end
            CSR_MTVEC, CSR_MEPC: begin
                cur_val  = mach_rdata_i;
                wmask    = MASK_ALIGN;
                sel.mach = 1'b1;
            end
            CSR_MSCRATCH, CSR_MCAUSE, CSR_MTVAL: begin
                cur_val  = mach_rdata_i;
                wmask    = '1;
                sel.mach = 1'b1;
            end
            CSR_MIP:     cur_val = mach_rdata_i;        // Follows irq_i only
            CSR_MCYCLE: begin
                cur_val      = mcycle_i[31:0];
                wmask        = '1;
                sel.cycle_lo = 1'b1;
            end
            CSR_MCYCLEH: begin
                cur_val      = mcycle_i[63:32];
                wmask        = '1;
                sel.cycle_hi = 1'b1;
            end
            CSR_MINSTRET: begin
                cur_val        = minstret_i[31:0];
                wmask          = '1;
                sel.instret_lo = 1'b1;
            end
            CSR_MINSTRETH: begin
                cur_val        = minstret_i[63:32];
                wmask          = '1;
                sel.instret_hi = 1'b1;
            end
            CSR_CYCLE:    cur_val = mcycle_i[31:0];
            CSR_CYCLEH:   cur_val = mcycle_i[63:32];
            CSR_INSTRET:  cur_val = minstret_i[31:0];
            CSR_INSTRETH: cur_val = minstret_i[63:32];
            CSR_TIME:     cur_val = mtime_i[31:0];
            CSR_TIMEH:    cur_val = mtime_i[63:32];
            CSR_MHARTID:  cur_val = HART_ID;
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MCONFIGPTR: cur_val = '0;
            default: ;                                  // Unknown reads zero
        endcase
    end

    always_comb begin
        case (req_i.op)
            CSR_WRITE: op_val = req_i.wdata;
            CSR_SET:   op_val = cur_val | req_i.wdata;
            CSR_CLEAR: op_val = cur_val & ~req_i.wdata;
            default:   op_val = cur_val;                // Reserved encoding
        endcase
    end

    // Bits outside the mask keep their value
    assign wr_o.data  = (cur_val & ~wmask) | (op_val & wmask);
    assign wr_o.sel   = sel;
    assign wr_o.valid = req_i.write_en && !req_i.killed;

    assign rdata_o = (req_i.read_en && !req_i.killed) ? cur_val : '0;

endmodule

`default_nettype wire

//--- csr_counters.sv
// Cycle and instret counters
`timescale 1ns/1ps
`default_nettype none

module csr_counters
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_wr_t     wr_i,
    input  logic        retire_i,
    output logic [63:0] mcycle_o,
    output logic [63:0] minstret_o
);

    // A written half overrides its own increment
    function automatic logic [63:0] next_count(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input logic [31:0] data
    );
        logic [63:0] nxt;
        nxt = cur + {63'b0, inc};
        if (wr_lo) begin
            nxt[31:0] = data;
        end
        if (wr_hi) begin
            nxt[63:32] = data;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= next_count(mcycle_o, 1'b1, wr_i.valid && wr_i.sel.cycle_lo,
                                     wr_i.valid && wr_i.sel.cycle_hi, wr_i.data);
            minstret_o <= next_count(minstret_o, retire_i, wr_i.valid && wr_i.sel.instret_lo,
                                     wr_i.valid && wr_i.sel.instret_hi, wr_i.data);
        end
    end

endmodule

`default_nettype wire

//--- csr_machine_regs.sv
// Machine trap registers
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs
    import csr_pkg::*;
#(
    parameter logic [31:0] MTVEC_RESET = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  csr_addr_e   addr_i,
    input  csr_wr_t     wr_i,
    input  trap_req_t   trap_i,
    input  logic [31:0] irq_i,
    output logic [31:0] rdata_o,
    output logic        interrupt_pending_o,
    output priv_e       privilege_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

    logic [31:0] mstatus;
    logic [31:0] misa;
    logic [31:0] mie;
    logic [31:0] mtvec_q;
    logic [31:0] mscratch;
    logic [31:0] mepc_q;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mip;
    priv_e       privilege;

    logic [31:0] irq_active;
    logic        pending_next;
    irq_code_e   irq_next;
    irq_code_e   irq_code;     // Cause latched with pending

    assign privilege_o = privilege;
    assign mtvec_o     = mtvec_q;
    assign mepc_o      = mepc_q;

    // Interrupt ranking, external first
    assign irq_active = mie & mip;

    always_comb begin
        if (irq_active[M_EXT_INT]) begin
            irq_next = M_EXT_INT;
        end else if (irq_active[M_SW_INT]) begin
            irq_next = M_SW_INT;
        end else begin
            irq_next = M_TIM_INT;
        end
    end

    assign pending_next = mstatus[MSTATUS_MIE] && (irq_active != '0)
                          && !trap_i.interrupt_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            mip                 <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip                 <= irq_i;           // One cycle sample
            interrupt_pending_o <= pending_next;
        end
    end

    always_ff @(posedge clk) begin
        if (pending_next) begin
            irq_code <= irq_next;
        end
    end

    // Priority is mret, trap entry, then CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus   <= '0;
            misa      <= MISA_VALUE;
            mie       <= '0;
            mtvec_q   <= MTVEC_RESET;
            mscratch  <= '0;
            mepc_q    <= '0;
            mcause    <= '0;
            mtval     <= '0;
            privilege <= PRIV_M;
        end else if (trap_i.mret) begin
            mstatus[MSTATUS_MIE] <= mstatus[MSTATUS_MPIE];
            privilege            <= priv_e'(mstatus[MSTATUS_MPP +: 2]);
        end else if (trap_i.raise_exception || trap_i.interrupt_ack) begin
            mstatus[MSTATUS_MPP +: 2] <= privilege;
            mstatus[MSTATUS_MPIE]     <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]      <= 1'b0;
            privilege                 <= PRIV_M;
            if (trap_i.raise_exception) begin
                mcause <= {1'b0, 26'b0, trap_i.exc_code};
                // Return past the faulting instruction unless it is ecall M or ebreak
                if (trap_i.exc_code == EXC_ECALL_M || trap_i.exc_code == EXC_BREAKPOINT) begin
                    mepc_q <= trap_i.pc;
                end else begin
                    mepc_q <= trap_i.pc + 32'd4;
                end
                mtval <= (trap_i.exc_code == EXC_ILLEGAL_INSTR) ? trap_i.instruction
                                                                : trap_i.pc;
            end else begin
                mcause <= {1'b1, 26'b0, irq_code};
                mepc_q <= trap_i.jump ? trap_i.jump_target : trap_i.pc;
            end
        end else if (wr_i.valid && wr_i.sel.mach) begin
            case (addr_i)
                CSR_MSTATUS:  mstatus  <= wr_i.data;
                CSR_MISA:     misa     <= wr_i.data;
                CSR_MIE:      mie      <= wr_i.data;
                CSR_MTVEC:    mtvec_q  <= wr_i.data;
                CSR_MSCRATCH: mscratch <= wr_i.data;
                CSR_MEPC:     mepc_q   <= wr_i.data;
                CSR_MCAUSE:   mcause   <= wr_i.data;
                CSR_MTVAL:    mtval    <= wr_i.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr_i)
            CSR_MSTATUS:  rdata_o = mstatus;
            CSR_MISA:     rdata_o = misa;
            CSR_MIE:      rdata_o = mie;
            CSR_MTVEC:    rdata_o = mtvec_q;
            CSR_MSCRATCH: rdata_o = mscratch;
            CSR_MEPC:     rdata_o = mepc_q;
            CSR_MCAUSE:   rdata_o = mcause;
            CSR_MTVAL:    rdata_o = mtval;
            CSR_MIP:      rdata_o = mip;
            default:      rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- csr_pkg.sv
// CSR unit shared types
`default_nettype none

package csr_pkg;

    // Operation encoding follows funct3[1:0]
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [11:0] {
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MCYCLE     = 12'hB00,
        CSR_MINSTRET   = 12'hB02,
        CSR_MCYCLEH    = 12'hB80,
        CSR_MINSTRETH  = 12'hB82,
        CSR_CYCLE      = 12'hC00,   // User read-only shadows
        CSR_TIME       = 12'hC01,
        CSR_INSTRET    = 12'hC02,
        CSR_CYCLEH     = 12'hC80,
        CSR_TIMEH      = 12'hC81,
        CSR_INSTRETH   = 12'hC82,
        CSR_MVENDORID  = 12'hF11,
        CSR_MARCHID    = 12'hF12,
        CSR_MIMPID     = 12'hF13,
        CSR_MHARTID    = 12'hF14,
        CSR_MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_e;

    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED = 5'd0,
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_ECALL_U          = 5'd8,
        EXC_ECALL_M          = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef struct packed {
        logic        read_en;
        logic        write_en;
        logic        killed;    // Instruction squashed in the pipeline
        csr_op_e     op;
        logic [11:0] addr;      // Raw address, may be unimplemented
        logic [31:0] wdata;
    } csr_req_t;

    // One-hot write target
    typedef struct packed {
        logic mach;
        logic cycle_lo;
        logic cycle_hi;
        logic instret_lo;
        logic instret_hi;
    } csr_wr_sel_t;

    typedef struct packed {
        csr_wr_sel_t sel;
        logic        valid;
        logic [31:0] data;      // Already merged with the mask
    } csr_wr_t;

    typedef struct packed {
        logic        raise_exception;
        logic        mret;
        logic        interrupt_ack;
        exc_code_e   exc_code;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic        jump;
        logic [31:0] jump_target;
    } trap_req_t;

    localparam logic [31:0] MISA_VALUE = 32'h4000_0100;   // RV32I

    // mstatus field positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;

endpackage

`default_nettype wire

//--- csr_unit.sv
// Machine-mode CSR unit
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter logic [31:0] HART_ID     = 32'd0,
    parameter logic [31:0] MTVEC_RESET = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  csr_req_t    req_i,
    input  trap_req_t   trap_i,
    input  logic [31:0] irq_i,          // Level per interrupt line
    input  logic [63:0] mtime_i,
    input  logic        retire_i,
    output logic [31:0] rdata_o,
    output logic        interrupt_pending_o,
    output priv_e       privilege_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

    csr_addr_e   mach_addr;
    csr_wr_t     wr;
    logic [31:0] mach_rdata;
    logic [63:0] mcycle;
    logic [63:0] minstret;

    csr_access #(
        .HART_ID(HART_ID)
    ) u_access (
        .req_i       (req_i),
        .mach_rdata_i(mach_rdata),
        .mcycle_i    (mcycle),
        .minstret_i  (minstret),
        .mtime_i     (mtime_i),
        .mach_addr_o (mach_addr),
        .wr_o        (wr),
        .rdata_o     (rdata_o)
    );

    csr_machine_regs #(
        .MTVEC_RESET(MTVEC_RESET)
    ) u_machine_regs (
        .clk                (clk),
        .reset              (reset),
        .addr_i             (mach_addr),
        .wr_i               (wr),
        .trap_i             (trap_i),
        .irq_i              (irq_i),
        .rdata_o            (mach_rdata),
        .interrupt_pending_o(interrupt_pending_o),
        .privilege_o        (privilege_o),
        .mtvec_o            (mtvec_o),
        .mepc_o             (mepc_o)
    );

    csr_counters u_counters (
        .clk       (clk),
        .reset     (reset),
        .wr_i      (wr),
        .retire_i  (retire_i),
        .mcycle_o  (mcycle),
        .minstret_o(minstret)
    );

endmodule

`default_nettype wire

//--- files.f
csr_pkg.sv
csr_access.sv
csr_machine_regs.sv
csr_counters.sv
csr_unit.sv
tb_csr_unit.sv

//--- tb_csr_unit.sv
// CSR unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
();

    logic        clk = 1'b0;
    logic        reset;
    csr_req_t    req;
    trap_req_t   trap;
    logic [31:0] irq_i;
    logic [63:0] mtime_i;
    logic        retire_i;
    logic [31:0] rdata;
    logic        pending;
    priv_e       privilege;
    logic [31:0] mtvec;
    logic [31:0] mepc;

    // Model slots for mscratch, mie, mtvec, misa, mip, mhartid, mvendorid and mstatus
    logic [31:0] model_val [0:7];
    logic [31:0] mask_tab [0:7];
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    priv_e       m_priv;

    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    integer      seed;
    logic [31:0] c1;
    logic [31:0] c2;
    logic [31:0] r;
    logic [11:0] addr_r;
    csr_op_e     op_r;
    int          n;
    int          i;

    csr_unit #(
        .HART_ID    (32'd5),
        .MTVEC_RESET(32'h100)
    ) DUT (
        .clk                (clk),
        .reset              (reset),
        .req_i              (req),
        .trap_i             (trap),
        .irq_i              (irq_i),
        .mtime_i            (mtime_i),
        .retire_i           (retire_i),
        .rdata_o            (rdata),
        .interrupt_pending_o(pending),
        .privilege_o        (privilege),
        .mtvec_o            (mtvec),
        .mepc_o             (mepc)
    );

    always #5 clk = ~clk;

    function automatic int slot_of(input logic [11:0] addr);
        case (addr)
            CSR_MSCRATCH: slot_of = 0;
            CSR_MIE:      slot_of = 1;
            CSR_MTVEC:    slot_of = 2;
            CSR_MISA:     slot_of = 3;
            CSR_MIP:      slot_of = 4;
            CSR_MHARTID:  slot_of = 5;
            CSR_MSTATUS:  slot_of = 7;
            default:      slot_of = 6;
        endcase
    endfunction

    // New value from the write, set and clear rules under a mask
    function automatic logic [31:0] model_op(input csr_op_e op, input logic [31:0] cur,
                                             input logic [31:0] data, input logic [31:0] mask);
        case (op)
            CSR_SET:   model_op = cur | (data & mask);
            CSR_CLEAR: model_op = cur & ~(data & mask);
            default:   model_op = (cur & ~mask) | (data & mask);
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic csr_cmd(input logic re, input logic we, input logic kill, input csr_op_e op,
                           input logic [11:0] addr, input logic [31:0] data,
                           input logic [31:0] exp);
        @(negedge clk);
        req.read_en  = re;
        req.write_en = we;
        req.killed   = kill;
        req.op       = op;
        req.addr     = addr;
        req.wdata    = data;
        @(posedge clk);
        check_eq(rdata, exp, $sformatf("rdata of %h", addr));
        if (we) begin
            @(negedge clk);
            req.write_en = 1'b0;    // One write per call
        end
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp);
        csr_cmd(1'b1, 1'b0, 1'b0, CSR_WRITE, addr, 32'h0, exp);
    endtask

    task automatic read_value(input logic [11:0] addr, output logic [31:0] val);
        @(negedge clk);
        req       = '0;
        req.read_en = 1'b1;
        req.addr  = addr;
        @(posedge clk);
        val = rdata;
    endtask

    // Read returns the old value and the model takes the new one
    task automatic masked_op(input csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] data, input logic kill);
        int          s;
        logic [31:0] old;
        s   = slot_of(addr);
        old = model_val[s];
        csr_cmd(1'b1, 1'b1, kill, op, addr, data, kill ? 32'h0 : old);
        if (!kill) begin
            model_val[s] = model_op(op, old, data, mask_tab[s]);
        end
    endtask

    task automatic drive_trap(input trap_req_t t);
        @(negedge clk);
        trap = t;
        @(posedge clk);
        @(negedge clk);
        trap = '0;
    endtask

    task automatic enter_trap();
        model_val[7][12:11] = m_priv;
        model_val[7][7]     = model_val[7][3];
        model_val[7][3]     = 1'b0;
        m_priv              = PRIV_M;
    endtask

    task automatic raise_exception(input exc_code_e code, input logic [31:0] pc,
                                   input logic [31:0] instr);
        trap_req_t t;
        t                 = '0;
        t.raise_exception = 1'b1;
        t.exc_code        = code;
        t.pc              = pc;
        t.instruction     = instr;
        drive_trap(t);
        enter_trap();
        m_mcause = {27'b0, code};
        m_mepc   = (code == EXC_ECALL_M || code == EXC_BREAKPOINT) ? pc : pc + 32'd4;
        m_mtval  = (code == EXC_ILLEGAL_INSTR) ? instr : pc;
    endtask

    task automatic ack_interrupt(input irq_code_e code, input logic [31:0] pc,
                                 input logic jump, input logic [31:0] target);
        trap_req_t t;
        t               = '0;
        t.interrupt_ack = 1'b1;
        t.pc            = pc;
        t.jump          = jump;
        t.jump_target   = target;
        drive_trap(t);
        enter_trap();
        m_mcause = {1'b1, 26'b0, code};
        m_mepc   = jump ? target : pc;
    endtask

    task automatic do_mret();
        trap_req_t t;
        t      = '0;
        t.mret = 1'b1;
        drive_trap(t);
        model_val[7][3] = model_val[7][7];
        m_priv          = priv_e'(model_val[7][12:11]);
    endtask

    task automatic check_trap();
        read_check(CSR_MSTATUS, model_val[7]);
        read_check(CSR_MEPC, m_mepc);
        read_check(CSR_MCAUSE, m_mcause);
        read_check(CSR_MTVAL, m_mtval);
        check_eq({30'b0, privilege}, {30'b0, m_priv}, "privilege_o");
        check_eq(mepc, m_mepc, "mepc_o");
    endtask

    task automatic wait_pending(input logic level);
        int cnt;
        cnt = 0;
        while (pending !== level && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        if (pending !== level) begin
            timeouts++;
            $display("Error at %0t: interrupt_pending_o did not become %0b within 20 cycles",
                     $time, level);
        end
    endtask

    initial begin
        seed     = 71;
        reset    = 1'b1;
        req      = '0;
        trap     = '0;
        irq_i    = '0;
        mtime_i  = '0;
        retire_i = 1'b0;
        model_val = '{32'h0, 32'h0, 32'h100, MISA_VALUE, 32'h0, 32'd5, 32'h0, 32'h0};
        mask_tab  = '{32'hFFFF_FFFF, 32'h888, 32'hFFFF_FFFC, 32'h3C00_0000, 32'h0, 32'h0,
                      32'h0, 32'h007E_19AA};
        m_mepc   = '0;
        m_mcause = '0;
        m_mtval  = '0;
        m_priv   = PRIV_M;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset values and read gating
        read_check(CSR_MHARTID, 32'd5);
        read_check(CSR_MISA, MISA_VALUE);
        read_check(CSR_MTVEC, 32'h100);
        check_eq(mtvec, 32'h100, "mtvec_o");
        read_check(12'h7C0, 32'h0);             // Unknown address
        masked_op(CSR_WRITE, CSR_MSCRATCH, 32'hDEAD_BEEF, 1'b0);
        csr_cmd(1'b0, 1'b0, 1'b0, CSR_WRITE, CSR_MSCRATCH, 32'h0, 32'h0);
        csr_cmd(1'b1, 1'b0, 1'b1, CSR_WRITE, CSR_MSCRATCH, 32'h0, 32'h0);
        masked_op(CSR_WRITE, CSR_MSCRATCH, 32'h1234_5678, 1'b1);
        read_check(CSR_MSCRATCH, model_val[0]);

        // Masked write, set and clear
        masked_op(CSR_SET, CSR_MSCRATCH, 32'h0000_00F0, 1'b0);
        masked_op(CSR_CLEAR, CSR_MSCRATCH, 32'hF000_000F, 1'b0);
        masked_op(CSR_WRITE, CSR_MIE, 32'hFFFF_FFFF, 1'b0);
        masked_op(CSR_CLEAR, CSR_MIE, 32'h0000_0008, 1'b0);
        masked_op(CSR_SET, CSR_MIE, 32'h0000_000F, 1'b0);
        masked_op(CSR_WRITE, CSR_MTVEC, 32'h1234_5677, 1'b0);
        masked_op(CSR_CLEAR, CSR_MTVEC, 32'hFFFF_FFFF, 1'b0);
        masked_op(CSR_SET, CSR_MISA, 32'hFFFF_FFFF, 1'b0);
        masked_op(CSR_CLEAR, CSR_MISA, 32'hFFFF_FFFF, 1'b0);
        masked_op(CSR_WRITE, CSR_MIP, 32'hFFFF_FFFF, 1'b0);
        masked_op(CSR_WRITE, CSR_MHARTID, 32'h0, 1'b0);
        masked_op(CSR_SET, CSR_MVENDORID, 32'hFFFF_FFFF, 1'b0);
        read_check(CSR_MTVEC, model_val[2]);
        check_eq(mtvec, model_val[2], "mtvec_o");
        read_check(CSR_MISA, MISA_VALUE);
        read_check(CSR_MHARTID, 32'd5);
        read_check(CSR_MIP, 32'h0);
        read_check(CSR_MVENDORID, 32'h0);

        // Exceptions and return with a drop to U
        masked_op(CSR_SET, CSR_MSTATUS, 32'h8, 1'b0);
        raise_exception(EXC_ILLEGAL_INSTR, 32'h200, 32'hDEAD_BEEF);
        check_trap();
        do_mret();
        check_trap();
        raise_exception(EXC_ECALL_M, 32'h300, 32'h0000_0073);
        check_trap();
        do_mret();
        masked_op(CSR_CLEAR, CSR_MSTATUS, 32'h1800, 1'b0);
        do_mret();
        check_trap();
        raise_exception(EXC_ECALL_U, 32'h400, 32'h0000_0073);
        check_trap();
        do_mret();
        check_trap();

        // Interrupt ranking and ack
        masked_op(CSR_WRITE, CSR_MIE, 32'h888, 1'b0);
        @(negedge clk);
        irq_i = 32'h888;
        wait_pending(1'b1);
        ack_interrupt(M_EXT_INT, 32'h600, 1'b1, 32'h500);
        wait_pending(1'b0);
        check_trap();
        do_mret();
        wait_pending(1'b1);
        ack_interrupt(M_EXT_INT, 32'h700, 1'b0, 32'h500);
        check_trap();
        @(negedge clk);
        irq_i = 32'h088;                        // Software and timer only
        do_mret();
        wait_pending(1'b1);
        ack_interrupt(M_SW_INT, 32'h710, 1'b0, 32'h0);
        wait_pending(1'b0);
        check_trap();
        @(negedge clk);
        irq_i = '0;

        // Counters and time
        read_value(CSR_CYCLE, c1);
        n = 5 + ($random(seed) & 15);
        repeat (n - 1) @(posedge clk);
        read_value(CSR_CYCLE, c2);
        check_eq(c2 - c1, n, "cycle difference");
        read_value(CSR_INSTRET, c1);
        n = 1 + ($random(seed) & 7);
        repeat (n) begin
            @(negedge clk);
            retire_i = 1'b1;
            @(negedge clk);
            retire_i = 1'b0;
        end
        read_value(CSR_INSTRET, c2);
        check_eq(c2 - c1, n, "instret difference");
        @(negedge clk);
        mtime_i = {$random(seed), $random(seed)};
        read_check(CSR_TIME, mtime_i[31:0]);
        read_check(CSR_TIMEH, mtime_i[63:32]);
        csr_cmd(1'b1, 1'b1, 1'b0, CSR_WRITE, CSR_MCYCLEH, 32'h42, 32'h0);
        read_check(CSR_MCYCLEH, 32'h42);
        read_check(CSR_CYCLEH, 32'h42);

        // Random traffic on mscratch and mie
        for (i = 0; i < 200; i++) begin
            r      = $random(seed);
            addr_r = r[0] ? CSR_MIE : CSR_MSCRATCH;
            case (r[2:1])
                2'd0:    op_r = CSR_WRITE;
                2'd1:    op_r = CSR_SET;
                default: op_r = CSR_CLEAR;
            endcase
            masked_op(op_r, addr_r, $random(seed), r[5:3] == 3'd0);
        end
        read_check(CSR_MSCRATCH, model_val[0]);
        read_check(CSR_MIE, model_val[1]);

        $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
